// File: hw/video_pkg.sv
package video_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // VGA channel format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int COLOR_WIDTH = 4;  // Bits per channel on the resistor DAC.

  // Full intensity; every frame of age shifts this right by one.
  localparam int MAX_LEVEL = (1 << COLOR_WIDTH) - 1;

  typedef logic [COLOR_WIDTH-1:0] level_t;  // One channel level.

endpackage

// File: hw/scope_pkg.sv
package scope_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ADC samples and plot commands
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int ADC_WIDTH = 10;  // Bits of one X or Y sample.

  // Colour code, one bit per channel.
  localparam int CODE_WIDTH = 3;
  localparam int CODE_RED   = 2;
  localparam int CODE_GRN   = 1;
  localparam int CODE_BLU   = 0;

  localparam logic [CODE_WIDTH-1:0] CODE_EMPTY = '0;  // No point stored here.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame stamps
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int STAMP_WIDTH = 3;            // Frame counter wraps at 8.
  localparam int AGE_WIDTH   = STAMP_WIDTH;  // Age is a stamp difference.

endpackage

// File: hw/adc_sampler.sv
`timescale 1ns/10ps

module adc_sampler #(
  parameter int FB_X_BITS = 8,
  parameter int FB_Y_BITS = 8
) (
  input  logic                             pixel_clk,
  input  logic                             rst_n,
  input  logic                             adc_strobe,
  input  logic [scope_pkg::ADC_WIDTH-1:0]  adc_x,
  input  logic [scope_pkg::ADC_WIDTH-1:0]  adc_y,
  input  logic                             adc_red,
  input  logic                             adc_grn,
  input  logic                             adc_blu,
  input  logic                             plot_ready,
  output logic                             plot_valid,
  output logic [FB_X_BITS-1:0]             plot_x,
  output logic [FB_Y_BITS-1:0]             plot_y,
  output logic [scope_pkg::CODE_WIDTH-1:0] plot_code,
  output logic                             sample_overrun
);

  import scope_pkg::*;

  localparam int CMD_WIDTH = FB_X_BITS + FB_Y_BITS + CODE_WIDTH;

  logic [CMD_WIDTH-1:0]  queue [2];
  logic [CODE_WIDTH-1:0] code_in;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  wr_ptr;
  logic                  rd_ptr;
  logic [1:0]            count;
  logic                  push;
  logic                  pop;

  always_comb begin
    code_in           = CODE_EMPTY;
    code_in[CODE_RED] = adc_red;
    code_in[CODE_GRN] = adc_grn;
    code_in[CODE_BLU] = adc_blu;
  end

  // Top bits of each axis select the buffer cell.
  assign cmd_in = {adc_x[ADC_WIDTH-1 -: FB_X_BITS], adc_y[ADC_WIDTH-1 -: FB_Y_BITS], code_in};

  assign pop  = plot_valid && plot_ready;
  assign push = adc_strobe && (count != 2'd2 || pop);  // Full with no pop drops the sample.

  always_ff @(posedge pixel_clk) begin
    if (push) begin
      queue[wr_ptr] <= cmd_in;
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      wr_ptr         <= 1'b0;
      rd_ptr         <= 1'b0;
      count          <= 2'd0;
      sample_overrun <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= !wr_ptr;
      end
      if (pop) begin
        rd_ptr <= !rd_ptr;
      end
      count <= count + {1'b0, push} - {1'b0, pop};
      if (adc_strobe && !push) begin
        sample_overrun <= 1'b1;  // Sticky until reset.
      end
    end
  end

  assign plot_valid                    = count != 2'd0;
  assign {plot_x, plot_y, plot_code} = queue[rd_ptr];

  assert property (@(posedge pixel_clk) disable iff (!rst_n)
    plot_valid && !plot_ready |=> plot_valid && $stable({plot_x, plot_y, plot_code}))
    else $error("adc_sampler: plot command changed while stalled");

endmodule

// File: hw/frame_buffer.sv
`timescale 1ns/10ps

module frame_buffer #(
  parameter int FB_X_BITS = 8,
  parameter int FB_Y_BITS = 8,
  parameter int PERSIST   = 3
) (
  input  logic                              pixel_clk,
  input  logic                              rst_n,
  input  logic                              plot_valid,
  output logic                              plot_ready,
  input  logic [FB_X_BITS-1:0]              plot_x,
  input  logic [FB_Y_BITS-1:0]              plot_y,
  input  logic [scope_pkg::CODE_WIDTH-1:0]  plot_code,
  input  logic [FB_X_BITS-1:0]              fb_x,
  input  logic [FB_Y_BITS-1:0]              fb_y,
  input  logic                              in_fb,
  input  logic [scope_pkg::STAMP_WIDTH-1:0] frame_count,
  output logic [scope_pkg::CODE_WIDTH-1:0]  scan_code,
  output logic [scope_pkg::AGE_WIDTH-1:0]   scan_age
);

  import scope_pkg::*;

  localparam int ADDR_BITS = FB_X_BITS + FB_Y_BITS;
  localparam int DEPTH     = 1 << ADDR_BITS;

  logic [CODE_WIDTH+STAMP_WIDTH-1:0] mem [DEPTH];  // Code in the upper bits, stamp below.

  logic [ADDR_BITS-1:0]   plot_addr;
  logic [ADDR_BITS-1:0]   scan_addr;
  logic                   plot_fire;
  logic [CODE_WIDTH-1:0]  rd_code;
  logic [STAMP_WIDTH-1:0] rd_stamp;
  logic [STAMP_WIDTH-1:0] rd_frame;
  logic [ADDR_BITS-1:0]   rd_addr;
  logic                   rd_valid;
  logic                   rd_hit;
  logic [AGE_WIDTH-1:0]   age;
  logic                   expired;
  logic                   scrub_next;
  logic                   scrub_req;
  logic [ADDR_BITS-1:0]   scrub_addr;
  logic [CODE_WIDTH-1:0]  scrub_code;
  logic [STAMP_WIDTH-1:0] scrub_stamp;
  logic [AGE_WIDTH-1:0]   scrub_age;

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  assign plot_addr  = {plot_y, plot_x};
  assign scan_addr  = {fb_y, fb_x};
  assign plot_ready = !scrub_req;  // The scrub owns the write port for one cycle.
  assign plot_fire  = plot_valid && plot_ready;

  always @(posedge pixel_clk) begin
    if (scrub_req) begin
      mem[scrub_addr] <= {CODE_EMPTY, STAMP_WIDTH'(0)};
    end else if (plot_fire) begin
      mem[plot_addr] <= {plot_code, frame_count};
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (in_fb) begin
      {rd_code, rd_stamp} <= mem[scan_addr];
      rd_addr             <= scan_addr;
      rd_frame            <= frame_count;
    end
    scrub_addr <= rd_addr;
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      rd_valid  <= 1'b0;
      rd_hit    <= 1'b0;
      scrub_req <= 1'b0;
    end else begin
      rd_valid  <= in_fb;
      rd_hit    <= plot_fire && plot_addr == scan_addr;  // Read returned the old entry.
      scrub_req <= scrub_next;
    end
  end

  assign age       = rd_frame - rd_stamp;  // Wraps modulo 8 with the stamp.
  assign expired   = age >= AGE_WIDTH'(PERSIST);
  assign scan_code = (rd_valid && !expired) ? rd_code : CODE_EMPTY;
  assign scan_age  = age;

  // A plot to the same cell on either side of the read keeps the fresh point.
  assign scrub_next = rd_valid && expired && rd_code != CODE_EMPTY && !rd_hit &&
                      !(plot_fire && plot_addr == rd_addr);

  // Entry that the scrub is about to clear.
  assign {scrub_code, scrub_stamp} = mem[scrub_addr];
  assign scrub_age                 = frame_count - scrub_stamp;

  assert property (@(posedge pixel_clk) disable iff (!rst_n)
    scrub_req |-> scrub_code != CODE_EMPTY && scrub_age >= AGE_WIDTH'(PERSIST))
    else $error("frame_buffer: scrub hit a point that is still lit");

endmodule

// File: hw/raster_timing.sv
`timescale 1ns/10ps

module raster_timing #(
  parameter int FB_X_BITS = 8,
  parameter int FB_Y_BITS = 8,
  parameter int H_ACTIVE  = 640,
  parameter int H_FRONT   = 16,
  parameter int H_SYNC    = 96,
  parameter int H_BACK    = 48,
  parameter int V_ACTIVE  = 480,
  parameter int V_FRONT   = 10,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 33
) (
  input  logic                              pixel_clk,
  input  logic                              rst_n,
  output logic                              hsync,
  output logic                              vsync,
  output logic                              active,
  output logic                              in_fb,
  output logic [FB_X_BITS-1:0]              fb_x,
  output logic [FB_Y_BITS-1:0]              fb_y,
  output logic [scope_pkg::STAMP_WIDTH-1:0] frame_count
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_BITS  = $clog2(H_TOTAL);
  localparam int V_BITS  = $clog2(V_TOTAL);
  localparam int FB_W    = 1 << FB_X_BITS;
  localparam int FB_H    = 1 << FB_Y_BITS;

  logic [H_BITS-1:0] h_cnt;
  logic [V_BITS-1:0] v_cnt;
  logic              line_end;
  logic              frame_end;

  assign line_end  = h_cnt == H_BITS'(H_TOTAL - 1);
  assign frame_end = line_end && v_cnt == V_BITS'(V_TOTAL - 1);

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      h_cnt       <= '0;
      v_cnt       <= '0;
      frame_count <= '0;
    end else begin
      h_cnt <= line_end ? '0 : h_cnt + 1'b1;
      if (line_end) begin
        v_cnt <= frame_end ? '0 : v_cnt + 1'b1;
      end
      if (frame_end) begin
        frame_count <= frame_count + 1'b1;  // New stamp from the first pixel on.
      end
    end
  end

  assign active = h_cnt < H_ACTIVE && v_cnt < V_ACTIVE;
  assign in_fb  = h_cnt < FB_W && v_cnt < FB_H;
  assign hsync  = !(h_cnt >= H_ACTIVE + H_FRONT && h_cnt < H_ACTIVE + H_FRONT + H_SYNC);
  assign vsync  = !(v_cnt >= V_ACTIVE + V_FRONT && v_cnt < V_ACTIVE + V_FRONT + V_SYNC);
  assign fb_x   = FB_X_BITS'(h_cnt);
  assign fb_y   = FB_Y_BITS'(v_cnt);

  assert property (@(posedge pixel_clk) disable iff (!rst_n) in_fb |-> active)
    else $error("raster_timing: frame buffer reaches outside the active area");

endmodule

// File: hw/scanout.sv
`timescale 1ns/10ps

module scanout #(
  parameter int PERSIST = 3
) (
  input  logic                              pixel_clk,
  input  logic                              rst_n,
  input  logic [scope_pkg::CODE_WIDTH-1:0]  scan_code,
  input  logic [scope_pkg::AGE_WIDTH-1:0]   scan_age,
  input  logic                              active,
  input  logic                              hsync,
  input  logic                              vsync,
  output logic [video_pkg::COLOR_WIDTH-1:0] vga_red,
  output logic [video_pkg::COLOR_WIDTH-1:0] vga_grn,
  output logic [video_pkg::COLOR_WIDTH-1:0] vga_blu,
  output logic                              vga_hsync,
  output logic                              vga_vsync
);

  import scope_pkg::*;
  import video_pkg::*;

  logic   active_q;
  logic   hsync_q;
  logic   vsync_q;
  level_t level;

  assign level = level_t'(MAX_LEVEL >> scan_age);  // 15, 7, 3, 1 as the point ages.

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      active_q  <= 1'b0;
      hsync_q   <= 1'b1;
      vsync_q   <= 1'b1;
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
    end else begin
      active_q  <= active;  // Matches the buffer read latency.
      hsync_q   <= hsync;
      vsync_q   <= vsync;
      vga_hsync <= hsync_q;
      vga_vsync <= vsync_q;
      vga_red   <= (active_q && scan_code[CODE_RED]) ? level : '0;
      vga_grn   <= (active_q && scan_code[CODE_GRN]) ? level : '0;
      vga_blu   <= (active_q && scan_code[CODE_BLU]) ? level : '0;
    end
  end

  // The buffer must hide expired points before they reach the DAC.
  assert property (@(posedge pixel_clk) disable iff (!rst_n)
    scan_code != CODE_EMPTY |-> scan_age < AGE_WIDTH'(PERSIST))
    else $error("scanout: expired point delivered by the frame buffer");

endmodule

// File: hw/xy_scope.sv
`timescale 1ns/10ps

module xy_scope #(
  parameter int FB_X_BITS = 8,
  parameter int FB_Y_BITS = 8,
  parameter int H_ACTIVE  = 640,
  parameter int H_FRONT   = 16,
  parameter int H_SYNC    = 96,
  parameter int H_BACK    = 48,
  parameter int V_ACTIVE  = 480,
  parameter int V_FRONT   = 10,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 33,
  parameter int PERSIST   = 3  // Frames a point stays lit, 1 to 4.
) (
  input  logic                              pixel_clk,
  input  logic                              rst_n,
  input  logic                              adc_strobe,
  input  logic [scope_pkg::ADC_WIDTH-1:0]   adc_x,
  input  logic [scope_pkg::ADC_WIDTH-1:0]   adc_y,
  input  logic                              adc_red,
  input  logic                              adc_grn,
  input  logic                              adc_blu,
  output logic [video_pkg::COLOR_WIDTH-1:0] vga_red,
  output logic [video_pkg::COLOR_WIDTH-1:0] vga_grn,
  output logic [video_pkg::COLOR_WIDTH-1:0] vga_blu,
  output logic                              vga_hsync,
  output logic                              vga_vsync,
  output logic                              sample_overrun
);

  import scope_pkg::*;

  logic                   plot_valid;
  logic                   plot_ready;
  logic [FB_X_BITS-1:0]   plot_x;
  logic [FB_Y_BITS-1:0]   plot_y;
  logic [CODE_WIDTH-1:0]  plot_code;
  logic [FB_X_BITS-1:0]   fb_x;
  logic [FB_Y_BITS-1:0]   fb_y;
  logic                   in_fb;
  logic                   active;
  logic                   hsync;
  logic                   vsync;
  logic [STAMP_WIDTH-1:0] frame_count;
  logic [CODE_WIDTH-1:0]  scan_code;
  logic [AGE_WIDTH-1:0]   scan_age;

  adc_sampler #(
    .FB_X_BITS(FB_X_BITS),
    .FB_Y_BITS(FB_Y_BITS)
  ) adc_sampler_i (
    .pixel_clk     (pixel_clk),
    .rst_n         (rst_n),
    .adc_strobe    (adc_strobe),
    .adc_x         (adc_x),
    .adc_y         (adc_y),
    .adc_red       (adc_red),
    .adc_grn       (adc_grn),
    .adc_blu       (adc_blu),
    .plot_ready    (plot_ready),
    .plot_valid    (plot_valid),
    .plot_x        (plot_x),
    .plot_y        (plot_y),
    .plot_code     (plot_code),
    .sample_overrun(sample_overrun)
  );

  frame_buffer #(
    .FB_X_BITS(FB_X_BITS),
    .FB_Y_BITS(FB_Y_BITS),
    .PERSIST  (PERSIST)
  ) frame_buffer_i (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .plot_valid (plot_valid),
    .plot_ready (plot_ready),
    .plot_x     (plot_x),
    .plot_y     (plot_y),
    .plot_code  (plot_code),
    .fb_x       (fb_x),
    .fb_y       (fb_y),
    .in_fb      (in_fb),
    .frame_count(frame_count),
    .scan_code  (scan_code),
    .scan_age   (scan_age)
  );

  raster_timing #(
    .FB_X_BITS(FB_X_BITS),
    .FB_Y_BITS(FB_Y_BITS),
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) raster_timing_i (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .hsync      (hsync),
    .vsync      (vsync),
    .active     (active),
    .in_fb      (in_fb),
    .fb_x       (fb_x),
    .fb_y       (fb_y),
    .frame_count(frame_count)
  );

  scanout #(
    .PERSIST(PERSIST)
  ) scanout_i (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .scan_code(scan_code),
    .scan_age (scan_age),
    .active   (active),
    .hsync    (hsync),
    .vsync    (vsync),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync)
  );

endmodule

// File: bench/xy_scope_tb.sv
`timescale 1ns/10ps

module xy_scope_tb;

  import video_pkg::*;
  import scope_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Small raster and buffer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int FB_X_BITS    = 4;
  localparam int FB_Y_BITS    = 4;
  localparam int FB_W         = 1 << FB_X_BITS;
  localparam int FB_H         = 1 << FB_Y_BITS;
  localparam int H_ACTIVE     = 24;
  localparam int H_FRONT      = 2;
  localparam int H_SYNC       = 3;
  localparam int H_BACK       = 2;
  localparam int V_ACTIVE     = 20;
  localparam int V_FRONT      = 1;
  localparam int V_SYNC       = 2;
  localparam int V_BACK       = 1;
  localparam int PERSIST      = 3;
  localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int CLK_PERIOD   = 20;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int TEST_FRAMES  = 22;  // Frames the whole sequence below runs through.
  localparam int X_SHIFT      = ADC_WIDTH - FB_X_BITS;
  localparam int Y_SHIFT      = ADC_WIDTH - FB_Y_BITS;

  logic                   pixel_clk;
  logic                   rst_n;
  logic                   adc_strobe;
  logic [ADC_WIDTH-1:0]   adc_x;
  logic [ADC_WIDTH-1:0]   adc_y;
  logic                   adc_red;
  logic                   adc_grn;
  logic                   adc_blu;
  logic [COLOR_WIDTH-1:0] vga_red;
  logic [COLOR_WIDTH-1:0] vga_grn;
  logic [COLOR_WIDTH-1:0] vga_blu;
  logic                   vga_hsync;
  logic                   vga_vsync;
  logic                   sample_overrun;

  logic [2:0] code_img [FB_W*FB_H];  // Expected buffer contents, red in the top bit.
  int         stamp_img [FB_W*FB_H];
  int         h_pos     = 0;         // Pixel now on the VGA pins.
  int         v_pos     = 0;
  int         ref_frame = 0;
  bit         synced    = 1'b0;
  int         errors    = 0;
  int         checks    = 0;

  xy_scope #(
    .FB_X_BITS(FB_X_BITS),
    .FB_Y_BITS(FB_Y_BITS),
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK),
    .PERSIST  (PERSIST)
  ) UUT (
    .pixel_clk     (pixel_clk),
    .rst_n         (rst_n),
    .adc_strobe    (adc_strobe),
    .adc_x         (adc_x),
    .adc_y         (adc_y),
    .adc_red       (adc_red),
    .adc_grn       (adc_grn),
    .adc_blu       (adc_blu),
    .vga_red       (vga_red),
    .vga_grn       (vga_grn),
    .vga_blu       (vga_blu),
    .vga_hsync     (vga_hsync),
    .vga_vsync     (vga_vsync),
    .sample_overrun(sample_overrun)
  );

  initial begin
    pixel_clk = 1'b0;
    forever #(CLK_PERIOD / 2) pixel_clk = ~pixel_clk;
  end

  initial begin
    #((TEST_FRAMES + 4) * FRAME_CYCLES * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish in %0d frames", TEST_FRAMES + 4);
    $display("Test failed");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference display model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic int point_age(int addr, int frame);
    return (frame - stamp_img[addr]) & ((1 << STAMP_WIDTH) - 1);
  endfunction

  function automatic logic [3*COLOR_WIDTH-1:0] expected_rgb(int h, int v, int frame);
    logic [2:0]             code;
    int                     age;
    logic [COLOR_WIDTH-1:0] level;
    expected_rgb = '0;
    if (h < FB_W && v < FB_H) begin
      code  = code_img[v*FB_W + h];
      age   = point_age(v*FB_W + h, frame);
      level = COLOR_WIDTH'(MAX_LEVEL >> age);  // One halving per frame of age.
      if (age < PERSIST) begin
        expected_rgb = {code[2] ? level : '0, code[1] ? level : '0, code[0] ? level : '0};
      end
    end
  endfunction

  // Follows the raster from the sync edges and compares every pixel.
  initial begin : compare_display
    logic [3*COLOR_WIDTH-1:0] exp_rgb;
    logic                     hs_q;
    logic                     vs_q;
    int                       addr;
    hs_q = 1'b1;
    vs_q = 1'b1;
    forever begin
      @(negedge pixel_clk);
      if (!rst_n) begin
        synced = 1'b0;
      end else begin
        if (hs_q && !vga_hsync) begin
          h_pos = H_ACTIVE + H_FRONT;
        end else begin
          h_pos = (h_pos + 1) % H_TOTAL;
        end
        if (synced && h_pos == 0) begin
          v_pos = v_pos + 1;
          if (v_pos == V_TOTAL) begin
            v_pos     = 0;
            ref_frame = ref_frame + 1;
          end
        end
        if (vs_q && !vga_vsync) begin
          h_pos  = 0;
          v_pos  = V_ACTIVE + V_FRONT;
          synced = 1'b1;
        end
        if (synced) begin
          exp_rgb = expected_rgb(h_pos, v_pos, ref_frame);
          checks  = checks + 1;
          if ({vga_red, vga_grn, vga_blu} != exp_rgb) begin
            errors = errors + 1;
            $display("FAIL %0t: pixel (%0d,%0d) frame %0d shows %h, expected %h",
                     $time, h_pos, v_pos, ref_frame, {vga_red, vga_grn, vga_blu}, exp_rgb);
          end
          if (h_pos < FB_W && v_pos < FB_H) begin
            addr = v_pos*FB_W + h_pos;
            if (point_age(addr, ref_frame) >= PERSIST) begin
              code_img[addr] = 3'b000;  // Scrubbed on its first expired scan.
            end
          end
        end
      end
      hs_q = vga_hsync;
      vs_q = vga_vsync;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic drive_sample(input int x, input int y, input logic [2:0] code);
    adc_strobe <= 1'b1;
    adc_x      <= ADC_WIDTH'((x << X_SHIFT) | ($urandom % (1 << X_SHIFT)));
    adc_y      <= ADC_WIDTH'((y << Y_SHIFT) | ($urandom % (1 << Y_SHIFT)));
    adc_red    <= code[2];
    adc_grn    <= code[1];
    adc_blu    <= code[0];
    code_img[y*FB_W + x]  = code;
    stamp_img[y*FB_W + x] = ref_frame;
  endtask

  task automatic spaced_sample(input int x, input int y, input logic [2:0] code);
    @(posedge pixel_clk);
    drive_sample(x, y, code);
    @(posedge pixel_clk);
    adc_strobe <= 1'b0;
    repeat (2) @(posedge pixel_clk);
  endtask

  // Keeps a plot out of the rows that the scan reads in the next few cycles.
  function automatic int avoid_scan_row(int row, int scan_row);
    if (row >= scan_row && row <= scan_row + 2) begin
      return (scan_row + 3) % FB_H;
    end
    return row;
  endfunction

  task automatic check_sync_timing();
    time t_fall;
    time t_rise;
    time t_next;
    @(negedge vga_hsync);
    t_fall = $time;
    @(posedge vga_hsync);
    t_rise = $time;
    @(negedge vga_hsync);
    t_next = $time;
    if (t_rise - t_fall != H_SYNC * CLK_PERIOD || t_next - t_fall != H_TOTAL * CLK_PERIOD) begin
      errors = errors + 1;
      $display("FAIL %0t: hsync pulse %0d and period %0d cycles", $time,
               (t_rise - t_fall) / CLK_PERIOD, (t_next - t_fall) / CLK_PERIOD);
    end
    @(negedge vga_vsync);
    t_fall = $time;
    @(posedge vga_vsync);
    t_rise = $time;
    if (t_rise - t_fall != V_SYNC * H_TOTAL * CLK_PERIOD) begin
      errors = errors + 1;
      $display("FAIL %0t: vsync pulse %0d cycles", $time, (t_rise - t_fall) / CLK_PERIOD);
    end
  endtask

  task automatic check_overrun(input logic expected, input string when);
    @(negedge pixel_clk);
    if (sample_overrun !== expected) begin
      errors = errors + 1;
      $display("FAIL %0t: sample_overrun is %b %s", $time, sample_overrun, when);
    end
  endtask

  initial begin : run_tests
    int row;
    void'($urandom(16));
    rst_n      = 1'b0;
    adc_strobe = 1'b0;
    adc_x      = '0;
    adc_y      = '0;
    adc_red    = 1'b0;
    adc_grn    = 1'b0;
    adc_blu    = 1'b0;
    for (int i = 0; i < FB_W*FB_H; i++) begin
      code_img[i]  = 3'b000;
      stamp_img[i] = 0;
    end
    check_overrun(1'b0, "in reset");
    if (vga_red !== '0 || vga_grn !== '0 || vga_blu !== '0 ||
        vga_hsync !== 1'b1 || vga_vsync !== 1'b1) begin
      errors = errors + 1;
      $display("FAIL %0t: VGA pins not idle in reset", $time);
    end
    @(posedge pixel_clk);
    rst_n <= 1'b1;

    check_sync_timing();

    // One point in blanking, then watch it fade past the stamp wrap.
    @(negedge vga_vsync);
    spaced_sample(11, 6, 3'b101);
    repeat (10) @(negedge vga_vsync);

    // Diagonal that expires in the random frame, one scrub per row.
    @(negedge vga_vsync);
    for (int i = 0; i < FB_W; i++) begin
      spaced_sample(i, i, 3'b010);
    end
    repeat (2) @(negedge vga_vsync);
    do @(posedge pixel_clk); while (!(v_pos == 0 && h_pos == 0));
    while (v_pos < V_ACTIVE) begin
      row = avoid_scan_row($urandom % FB_H, v_pos);
      spaced_sample($urandom % FB_W, row, 3'(1 + $urandom % 7));
    end
    repeat (2) @(negedge vga_vsync);
    check_overrun(1'b0, "after spaced strobes");

    // A full row expires together, and a burst hits its scrub run.
    @(negedge vga_vsync);
    for (int i = 0; i < FB_W; i++) begin
      spaced_sample(i, 5, 3'b111);
    end
    repeat (2) @(negedge vga_vsync);
    do @(posedge pixel_clk); while (!(v_pos == 5 && h_pos == 0));
    repeat (8) begin
      drive_sample(9, 12, 3'b011);
      @(posedge pixel_clk);
    end
    adc_strobe <= 1'b0;
    check_overrun(1'b1, "after a burst during scrubs");
    repeat (2) @(negedge vga_vsync);
    check_overrun(1'b1, "two frames after the burst");

    @(posedge pixel_clk);
    rst_n <= 1'b0;
    repeat (2) @(posedge pixel_clk);
    check_overrun(1'b0, "after reset");

    $display("%0d pixels checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: xy_scope.f
hw/video_pkg.sv
hw/scope_pkg.sv
hw/adc_sampler.sv
hw/frame_buffer.sv
hw/raster_timing.sv
hw/scanout.sv
hw/xy_scope.sv
bench/xy_scope_tb.sv

// File: Makefile
# Verilator build and run for the XY scope testbench.

SIM = obj_dir/Vxy_scope_tb

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

$(SIM): xy_scope.f $(wildcard hw/*.sv bench/*.sv)
	verilator --binary --assert -Wno-fatal --top-module xy_scope_tb \
		-Mdir obj_dir -f xy_scope.f

clean:
	rm -rf obj_dir
